// File: source/bram_macros.svh
// widths assume 64-bit words and a 16-bit byte address; NUM_BANKS must be a power of two
`ifndef BRAM_MACROS_SVH
`define BRAM_MACROS_SVH

// port side
`define DATA_W      64
`define STRB_W      8
`define ADDR_W      16

`define WORD_IDX_W  13   // 8192 words

// banking, low word index bits pick the bank
`define NUM_BANKS   4
`define BANK_SEL_W  2

`define ROW_W       11   // WORD_IDX_W - BANK_SEL_W
`define BANK_DEPTH  2048

`endif

// File: source/mem_pkg.sv
// vector types for the BRAM port and the bank split; widths come from bram_macros.svh
`default_nettype none

`include "bram_macros.svh"

package mem_pkg;

   // one port word
   typedef logic [`DATA_W-1:0] word_t;

   typedef logic [`STRB_W-1:0] strb_t;   // one strobe per byte

   // byte address as seen on ram_addr, bits 2:0 unused
   typedef logic [`ADDR_W-1:0] byte_addr_t;

   // address bits 4:3
   typedef logic [`BANK_SEL_W-1:0] bank_sel_t;

   // address bits 15:5
   typedef logic [`ROW_W-1:0] row_t;

endpackage

`default_nettype wire

// File: source/req_pkg.sv
// request and read tag records between decoder, banks and read return; no handshake fields
`default_nettype none

package req_pkg;

   // one request as seen by a single bank
   typedef struct packed {
      logic            en;       // this bank is addressed
      mem_pkg::strb_t  we;       // zero unless en
      mem_pkg::row_t   row;
      mem_pkg::word_t  wrdata;
   } bank_req_s;

   // every enabled access returns a word, write or not
   typedef struct packed {
      logic                valid;
      mem_pkg::bank_sel_t  bank;
   } rd_tag_s;

endpackage

`default_nettype wire

// File: source/bank_decode.sv
// takes a request on every edge with ram_en high, no back-pressure; ram_addr bits 2:0 ignored
`default_nettype none

`include "bram_macros.svh"

module bank_decode (
   input  wire                  ram_clk,
   input  wire                  rst_n,
   input  wire                  ram_en,
   input  wire mem_pkg::strb_t  ram_we,
   input  wire mem_pkg::byte_addr_t ram_addr,
   input  wire mem_pkg::word_t  ram_wrdata,
   output req_pkg::bank_req_s   bank_req [`NUM_BANKS],
   output req_pkg::rd_tag_s     rd_tag
);

   logic [`WORD_IDX_W-1:0] word_idx;
   mem_pkg::bank_sel_t     bank_sel;
   logic [`NUM_BANKS-1:0]  en_dec;

   logic [`NUM_BANKS-1:0]  en_q;
   logic                   tag_valid_q;
   mem_pkg::bank_sel_t     bank_q;
   mem_pkg::strb_t         we_q;
   mem_pkg::row_t          row_q;
   mem_pkg::word_t         wrdata_q;

   assign word_idx = ram_addr[`ADDR_W-1 -: `WORD_IDX_W];   // drop byte offset
   assign bank_sel = word_idx[`BANK_SEL_W-1:0];

   always_comb begin
      en_dec = '0;
      en_dec[bank_sel] = ram_en;
   end

   always_ff @(posedge ram_clk) begin
      if (!rst_n) begin
         en_q        <= '0;
         tag_valid_q <= 1'b0;
      end else begin
         en_q        <= en_dec;
         tag_valid_q <= ram_en;
      end
   end

   // request payload, only meaningful with an enable
   always_ff @(posedge ram_clk) begin
      if (ram_en) begin
         bank_q   <= bank_sel;
         we_q     <= ram_we;
         row_q    <= word_idx[`WORD_IDX_W-1:`BANK_SEL_W];
         wrdata_q <= ram_wrdata;
      end
   end

   always_comb begin
      for (int b = 0; b < `NUM_BANKS; b++) begin
         bank_req[b].en     = en_q[b];
         bank_req[b].we     = en_q[b] ? we_q : '0;   // idle banks never see strobes
         bank_req[b].row    = row_q;
         bank_req[b].wrdata = wrdata_q;
      end
      rd_tag.valid = tag_valid_q;
      rd_tag.bank  = bank_q;
   end

   // each tag toward read return pairs with exactly one bank access
   a_one_bank_per_tag: assert property (
      @(posedge ram_clk) disable iff (!rst_n)
      $onehot0(en_q) && (tag_valid_q == (|en_q))
   ) else $error("bank enables do not match the read tag");

endmodule

`default_nettype wire

// File: source/ram_bank.sv
// one bank, not cleared by reset and no init file; read word is write-first from captured row
`default_nettype none

`include "bram_macros.svh"

module ram_bank (
   input  wire                     ram_clk,
   input  wire req_pkg::bank_req_s bank_req,
   output mem_pkg::word_t          rddata
);

   mem_pkg::word_t mem [`BANK_DEPTH];
   mem_pkg::row_t  rd_row_q;

   // byte lane writes and read address capture on the same edge
   always_ff @(posedge ram_clk) begin
      if (bank_req.en) begin
         rd_row_q <= bank_req.row;
         for (int i = 0; i < `STRB_W; i++) begin
            if (bank_req.we[i]) begin
               mem[bank_req.row][i*8 +: 8] <= bank_req.wrdata[i*8 +: 8];
            end
         end
      end
   end

   // array already holds the new bytes here
   assign rddata = mem[rd_row_q];

   // decoder masks strobes on banks it did not select
   a_we_needs_en: assert property (
      @(posedge ram_clk)
      (bank_req.we != '0) |-> bank_req.en
   ) else $error("byte strobes on a bank that is not enabled");

endmodule

`default_nettype wire

// File: source/read_return.sv
// fixed latency return, one word per tag; ram_rddata holds its last value while ram_rd_valid low
`default_nettype none

`include "bram_macros.svh"

module read_return (
   input  wire                   ram_clk,
   input  wire                   rst_n,
   input  wire req_pkg::rd_tag_s rd_tag,
   input  wire mem_pkg::word_t   bank_rddata [`NUM_BANKS],
   output mem_pkg::word_t        ram_rddata,
   output logic                  ram_rd_valid
);

   logic               tag_valid_q;
   mem_pkg::bank_sel_t tag_bank_q;

   // tag stage lines up with the bank read register
   always_ff @(posedge ram_clk) begin
      if (!rst_n) begin
         tag_valid_q  <= 1'b0;
         ram_rd_valid <= 1'b0;
      end else begin
         tag_valid_q  <= rd_tag.valid;
         ram_rd_valid <= tag_valid_q;
      end
   end

   always_ff @(posedge ram_clk) begin
      if (rd_tag.valid) begin
         tag_bank_q <= rd_tag.bank;
      end
      if (tag_valid_q) begin
         ram_rddata <= bank_rddata[tag_bank_q];   // bank mux
      end
   end

   // no decoded request means no return two cycles on
   a_no_spurious_valid: assert property (
      @(posedge ram_clk) disable iff (!rst_n)
      !rd_tag.valid |-> ##2 !ram_rd_valid
   ) else $error("ram_rd_valid without a matching request");

endmodule

`default_nettype wire

// File: source/bram_top.sv
// banked 8192x64 RAM behind a plain BRAM port, read latency 2, one request per cycle, no stall
`default_nettype none

`include "bram_macros.svh"

module bram_top (
   input  wire                      ram_clk,
   input  wire                      rst_n,
   input  wire                      ram_en,
   input  wire mem_pkg::strb_t      ram_we,
   input  wire mem_pkg::byte_addr_t ram_addr,
   input  wire mem_pkg::word_t      ram_wrdata,
   output mem_pkg::word_t           ram_rddata,
   output logic                     ram_rd_valid
);

   req_pkg::bank_req_s bank_req    [`NUM_BANKS];
   req_pkg::rd_tag_s   rd_tag;
   mem_pkg::word_t     bank_rddata [`NUM_BANKS];

   bank_decode bank_decode_i (
      .ram_clk    ( ram_clk    ),
      .rst_n      ( rst_n      ),
      .ram_en     ( ram_en     ),
      .ram_we     ( ram_we     ),
      .ram_addr   ( ram_addr   ),
      .ram_wrdata ( ram_wrdata ),
      .bank_req   ( bank_req   ),
      .rd_tag     ( rd_tag     )
   );

   // banks interleaved on word address bits 1:0
   for (genvar b = 0; b < `NUM_BANKS; b++) begin : g_bank
      ram_bank ram_bank_i (
         .ram_clk  ( ram_clk        ),
         .bank_req ( bank_req[b]    ),
         .rddata   ( bank_rddata[b] )
      );
   end

   read_return read_return_i (
      .ram_clk      ( ram_clk      ),
      .rst_n        ( rst_n        ),
      .rd_tag       ( rd_tag       ),
      .bank_rddata  ( bank_rddata  ),
      .ram_rddata   ( ram_rddata   ),
      .ram_rd_valid ( ram_rd_valid )
   );

endmodule

`default_nettype wire

// File: verif/tb_clock.sv
// clock period 20 from time 0; rst_n low across the first two rising edges, then high for good
`default_nettype none

module tb_clock (
   output logic ram_clk,
   output logic rst_n
);

   localparam int HALF_PERIOD  = 10;
   localparam int RESET_CYCLES = 2;

   initial begin
      ram_clk = 1'b0;
      forever #(HALF_PERIOD) ram_clk = ~ram_clk;
   end

   initial begin
      rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge ram_clk);
      rst_n <= 1'b1;   // released on the edge, like the stimulus
   end

endmodule

`default_nettype wire

// File: verif/bram_checker.sv
// model covers all 8192 words but only compares bytes written since reset; expects latency 2
`default_nettype none

`include "bram_macros.svh"

module bram_checker (
   input  wire                      ram_clk,
   input  wire                      rst_n,
   input  wire                      ram_en,
   input  wire mem_pkg::strb_t      ram_we,
   input  wire mem_pkg::byte_addr_t ram_addr,
   input  wire mem_pkg::word_t      ram_wrdata,
   input  wire mem_pkg::word_t      ram_rddata,
   input  wire                      ram_rd_valid,
   output int                       checked_cnt,
   output int                       mismatch_errs,
   output int                       valid_errs
);

   localparam int LATENCY = 2;
   localparam int WORDS   = `NUM_BANKS * `BANK_DEPTH;

   typedef struct packed {
      logic [31:0]    edge_no;   // edge the request was sampled on
      mem_pkg::word_t word;
      mem_pkg::strb_t known;
   } expect_s;

   mem_pkg::word_t model_mem   [WORDS];
   mem_pkg::strb_t model_known [WORDS];   // one flag per byte
   expect_s        expect_q    [$];

   logic [31:0] edge_cnt   = '0;
   int          checked_n  = 0;
   int          mismatch_n = 0;
   int          valid_n    = 0;

   assign checked_cnt   = checked_n;
   assign mismatch_errs = mismatch_n;
   assign valid_errs    = valid_n;

   task automatic compare_word(input expect_s exp);
      logic bad;
      bad = 1'b0;
      for (int i = 0; i < `STRB_W; i++) begin
         if (exp.known[i] && (ram_rddata[i*8 +: 8] !== exp.word[i*8 +: 8])) begin
            bad = 1'b1;
         end
      end
      checked_n++;
      if (bad) begin
         mismatch_n++;
         $display("Mismatch at %0t: read 0x%h, expected 0x%h on bytes %b (edge %0d)",
                  $time, ram_rddata, exp.word, exp.known, exp.edge_no);
      end
   endtask

   // outputs seen here were set on the previous edge, hence one extra edge
   task automatic check_return;
      logic due;
      due = 1'b0;
      if (expect_q.size() > 0) begin
         due = (expect_q[0].edge_no + LATENCY + 1 == edge_cnt);
      end
      if (ram_rd_valid === 1'b1) begin
         if (due) begin
            compare_word(expect_q.pop_front());
         end else begin
            valid_n++;
            $display("extra ram_rd_valid at %0t with no request due", $time);
         end
      end else if (due) begin
         valid_n++;
         $display("missing ram_rd_valid at %0t for the request sampled on edge %0d",
                  $time, expect_q[0].edge_no);
         void'(expect_q.pop_front());
      end
   endtask

   // write-first, so the expected word already holds this request's bytes
   task automatic record_request;
      logic [`WORD_IDX_W-1:0] widx;
      expect_s                exp;
      widx = ram_addr[`ADDR_W-1:3];   // byte offset ignored
      for (int i = 0; i < `STRB_W; i++) begin
         if (ram_we[i]) begin
            model_mem[widx][i*8 +: 8] = ram_wrdata[i*8 +: 8];
            model_known[widx][i]      = 1'b1;
         end
      end
      exp.edge_no = edge_cnt;
      exp.word    = model_mem[widx];
      exp.known   = model_known[widx];
      expect_q.push_back(exp);
   endtask

   always @(posedge ram_clk) begin
      if (!rst_n) begin
         expect_q.delete();
         for (int w = 0; w < WORDS; w++) begin
            model_known[w] = '0;   // RAM content unknown after reset
            model_mem[w]   = '0;
         end
      end else begin
         check_return();
         // idle cycles carry zero strobes
         assert (ram_en === 1'b1 || ram_we === '0) else begin
            valid_n++;
            $display("byte strobes driven at %0t while ram_en is low", $time);
         end
         if (ram_en) begin
            record_request();
         end
      end
      edge_cnt++;
   end

endmodule

`default_nettype wire

// File: verif/bram_tb.sv
// random traffic in one 16-word window so banks and rows collide often; fixed LFSR seed
`default_nettype none

`include "bram_macros.svh"

module bram_tb;

   localparam int IDLE_CYCLES  = 6;
   localparam int STIM_CYCLES  = 3000;
   localparam int DRAIN_CYCLES = 20;
   localparam int CYCLE_LIMIT  = STIM_CYCLES + DRAIN_CYCLES + 80;   // reset, idle, slack

   localparam logic [31:0]             LFSR_SEED   = 32'h8a37;
   localparam logic [`WORD_IDX_W-5:0]  WINDOW_BASE = 9'h0b3;   // upper word index bits

   logic                ram_clk;
   logic                rst_n;
   logic                ram_en;
   mem_pkg::strb_t      ram_we;
   mem_pkg::byte_addr_t ram_addr;
   mem_pkg::word_t      ram_wrdata;
   mem_pkg::word_t      ram_rddata;
   logic                ram_rd_valid;

   int          checked_cnt;
   int          mismatch_errs;
   int          valid_errs;
   int          cycle_cnt = 0;
   logic [31:0] lfsr;

   tb_clock tb_clock_i (
      .ram_clk ( ram_clk ),
      .rst_n   ( rst_n   )
   );

   bram_top bram_top_i (
      .ram_clk      ( ram_clk      ),
      .rst_n        ( rst_n        ),
      .ram_en       ( ram_en       ),
      .ram_we       ( ram_we       ),
      .ram_addr     ( ram_addr     ),
      .ram_wrdata   ( ram_wrdata   ),
      .ram_rddata   ( ram_rddata   ),
      .ram_rd_valid ( ram_rd_valid )
   );

   bram_checker bram_checker_i (
      .ram_clk       ( ram_clk       ),
      .rst_n         ( rst_n         ),
      .ram_en        ( ram_en        ),
      .ram_we        ( ram_we        ),
      .ram_addr      ( ram_addr      ),
      .ram_wrdata    ( ram_wrdata    ),
      .ram_rddata    ( ram_rddata    ),
      .ram_rd_valid  ( ram_rd_valid  ),
      .checked_cnt   ( checked_cnt   ),
      .mismatch_errs ( mismatch_errs ),
      .valid_errs    ( valid_errs    )
   );

   // x^32 + x^22 + x^2 + x + 1, new bit enters at bit 0
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      logic fb;
      fb = s[31] ^ s[21] ^ s[1] ^ s[0];
      return {s[30:0], fb};
   endfunction

   task automatic take_bits(input int n, output logic [63:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_step(lfsr);
         v    = {v[62:0], lfsr[0]};
      end
   endtask

   task automatic drive_random_request;
      logic [63:0]    r;
      logic           en;
      logic [1:0]     kind;
      mem_pkg::strb_t we;
      logic [3:0]     win;
      logic [2:0]     off;
      take_bits(2, r);
      en = (r[1:0] != 2'b00);   // about three in four cycles busy
      take_bits(2, r);
      kind = r[1:0];
      take_bits(8, r);
      case (kind)
         2'd0:    we = '0;   // plain read
         2'd1:    we = '1;
         default: we = r[7:0];
      endcase
      if (!en) begin
         we = '0;   // idle cycles carry no strobes
      end
      take_bits(4, r);
      win = r[3:0];
      take_bits(3, r);
      off = r[2:0];
      take_bits(64, r);
      ram_en     <= en;
      ram_we     <= we;
      ram_addr   <= {WINDOW_BASE, win, off};
      ram_wrdata <= r;
   endtask

   task automatic finish_run;
      $display("checked %0d returns, %0d value errors, %0d valid errors",
               checked_cnt, mismatch_errs, valid_errs);
      if (checked_cnt == 0) begin
         $display("no read data reached the checker");
      end
      if (mismatch_errs == 0 && valid_errs == 0 && checked_cnt > 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   endtask

   initial begin : main
      ram_en     = 1'b0;
      ram_we     = '0;
      ram_addr   = '0;
      ram_wrdata = '0;
      lfsr       = LFSR_SEED;
      wait (rst_n === 1'b1);
      repeat (IDLE_CYCLES) @(posedge ram_clk);   // ram_rd_valid must stay low here
      repeat (STIM_CYCLES) begin
         @(posedge ram_clk);
         drive_random_request();
      end
      @(posedge ram_clk);
      ram_en <= 1'b0;
      ram_we <= '0;
      repeat (DRAIN_CYCLES) @(posedge ram_clk);
      finish_run();
   end

   always @(posedge ram_clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= CYCLE_LIMIT) begin
         $display("timeout after %0d cycles, stimulus did not complete", cycle_cnt);
         $display(">>> FAIL");
         $finish;
      end
   end

endmodule

`default_nettype wire

// File: sources.f
+incdir+source
source/mem_pkg.sv
source/req_pkg.sv
source/bank_decode.sv
source/ram_bank.sv
source/read_return.sv
source/bram_top.sv
verif/tb_clock.sv
verif/bram_checker.sv
verif/bram_tb.sv

// File: Makefile
# Verilator build and run for the banked BRAM testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = bram_tb
FILELIST  = sources.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(wildcard source/*.sv source/*.svh verif/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# status comes from the pass line in the simulator output
run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '>>> PASS'

clean:
	rm -rf $(OBJ_DIR)
